/* Makefile */
# Verilator build of the fetch unit testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_fetch_unit -f sim.f -o sim_fetch_unit

run: compile
	./obj_dir/sim_fetch_unit | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/fetch_fsm.sv */
`timescale 1ns/1ns

module fetch_fsm (
  input  logic                clk,
  input  logic                reset,
  input  logic [15:0]         data,
  input  logic                need_modrm,
  input  logic                need_off,
  input  logic                off_size,
  input  logic                need_imm,
  input  logic                imm_size,
  input  fetch_pkg::uop_idx_t ninstrs,
  input  fetch_pkg::ir_t      irs  [fetch_pkg::max_uops],
  input  logic [15:0]         offs [fetch_pkg::max_uops],
  input  logic [15:0]         imms [fetch_pkg::max_uops],
  input  fetch_pkg::uop_idx_t idx,
  input  logic                last,
  output logic                load_opcode,
  output logic                load_modrm,
  output logic                load_off,
  output logic                load_imm,
  output logic                seq_clear,
  output logic                seq_step,
  output fetch_pkg::ir_t      ir,
  output logic [15:0]         off,
  output logic [15:0]         imm,
  output logic                bytefetch,
  output logic                fetch_or_exec
);
  import fetch_pkg::*;

  fetch_state_t state, state_next;
  fetch_state_t after_off;   // where to go once the offset is in
  fetch_state_t to_exec;     // exec, or clear when nothing to issue
  ir_t          ir_r;
  logic [15:0]  off_r, imm_r;
  logic         fetching;
  logic         two_bytes;

  assign to_exec   = (ninstrs != 2'd0) ? st_exec : st_clear;
  assign after_off = need_imm ? st_imm : to_exec;

  always_comb begin
    state_next = state;
    case (state)
      st_opcode: state_next = need_modrm ? st_modrm : (need_off ? st_off : after_off);
      st_modrm:  state_next = need_off ? st_off : after_off;
      st_off:    state_next = after_off;
      st_imm:    state_next = to_exec;
      st_exec:   if (last) state_next = st_clear;
      st_clear:  state_next = st_idle;
      default:   state_next = st_opcode; // idle
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  assign load_opcode = (state == st_opcode);
  assign load_modrm  = (state == st_modrm);
  assign load_off    = (state == st_off);
  assign load_imm    = (state == st_imm);

  // restart the slot counter on the way into exec
  assign seq_clear = (state_next == st_exec) && (state != st_exec);
  assign seq_step  = (state == st_exec);

  // selected slot lands on the outputs one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      ir_r  <= '0;
      off_r <= '0;
      imm_r <= '0;
    end else if (state == st_exec) begin
      ir_r  <= irs[idx];
      off_r <= offs[idx];
      imm_r <= imms[idx];
    end else if (state == st_clear) begin
      ir_r <= '0;
    end
  end

  assign fetching  = (state == st_opcode) || (state == st_modrm) ||
                     (state == st_off) || (state == st_imm);
  assign two_bytes = ((state == st_off) && off_size) || ((state == st_imm) && imm_size);

  assign bytefetch = ~two_bytes;
  assign ir        = fetching ? add_ip : ir_r;
  assign imm       = fetching ? (two_bytes ? 16'd2 : 16'd1) : imm_r; // bytes consumed
  assign off       = fetching ? data : off_r; // word under pc while fetching

  assign fetch_or_exec = (state == st_exec) || (state == st_clear);

endmodule

/* hdl/fetch_pkg.sv */
package fetch_pkg;

  // micro-op word layout, msb first:
  // ac ab im ma by fun(3) t(3) wh wr(2) wm wf ad_d(4) ad_c(4) ad_b(4) ad_a(4) s(2)
  localparam int ir_size = 34;

  typedef logic [ir_size-1:0] ir_t;

  // register file codes shared by the modrm decode and the opcode table
  localparam logic [3:0] reg_bx   = 4'b0011;
  localparam logic [3:0] reg_bp   = 4'b0101;
  localparam logic [3:0] reg_si   = 4'b0110;
  localparam logic [3:0] reg_di   = 4'b0111;
  localparam logic [3:0] reg_cs   = 4'b1001;
  localparam logic [3:0] reg_none = 4'b1100; // no register
  localparam logic [3:0] reg_tmp  = 4'b1101;
  localparam logic [3:0] reg_ip   = 4'b1111;

  // segment select for memory micro-ops
  localparam logic [1:0] seg_ds = 2'b11;

  // ip <= ip + imm, shown while bytes are being fetched
  localparam ir_t add_ip = {
    1'b0, 1'b0, 1'b1, 1'b1, 1'b0,  // ac ab im ma by
    3'b100, 3'b000, 1'b0,          // fun t wh
    2'b01, 1'b0, 1'b0,             // wr wm wf
    reg_ip, 4'b0000, 4'b0000, reg_ip,
    2'b00
  };

  // most micro-ops per instruction
  localparam int max_uops = 3;

  typedef logic [1:0] uop_idx_t;

  typedef enum logic [3:0] {
    st_opcode = 4'h0,
    st_modrm  = 4'h1,
    st_off    = 4'h2,
    st_imm    = 4'h3,
    st_exec   = 4'h4,
    st_clear  = 4'h7,
    st_idle   = 4'h8
  } fetch_state_t;

endpackage

/* hdl/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
  input  logic           clk,
  input  logic           reset,
  input  logic [15:0]    cs,
  input  logic [15:0]    ip,
  input  logic [15:0]    data,
  output logic [19:0]    pc,
  output fetch_pkg::ir_t ir,
  output logic [15:0]    off,
  output logic [15:0]    imm,
  output logic           bytefetch,
  output logic           fetch_or_exec
);
  import fetch_pkg::*;

  logic        load_opcode, load_modrm, load_off, load_imm;
  logic [7:0]  opcode_q, modrm_q;
  logic [7:0]  opcode, modrm;
  logic [15:0] off_q, imm_q;
  logic [1:0]  mod;
  logic [2:0]  regm, rm;
  logic [3:0]  base, index;
  logic        need_off_mod, off_size_mod;
  logic        need_modrm, need_off, off_size, need_imm, imm_size;
  uop_idx_t    ninstrs, idx;
  ir_t         irs  [max_uops];
  logic [15:0] offs [max_uops];
  logic [15:0] imms [max_uops];
  logic        seq_clear, seq_step, last;

  assign pc = {cs, 4'b0000} + {4'b0000, ip};

  // decode sees the byte in flight during its own fetch cycle
  assign opcode = load_opcode ? data[7:0] : opcode_q;
  assign modrm  = load_modrm ? data[7:0] : modrm_q;

  operand_latch #(.payload_t(logic [7:0])) u_opcode_latch (
    .clk(clk), .reset(reset), .load(load_opcode), .d(data[7:0]), .q(opcode_q)
  );

  operand_latch #(.payload_t(logic [7:0])) u_modrm_latch (
    .clk(clk), .reset(reset), .load(load_modrm), .d(data[7:0]), .q(modrm_q)
  );

  operand_latch #(.payload_t(logic [15:0])) u_off_latch (
    .clk(clk), .reset(reset), .load(load_off), .d(data), .q(off_q)
  );

  operand_latch #(.payload_t(logic [15:0])) u_imm_latch (
    .clk(clk), .reset(reset), .load(load_imm), .d(data), .q(imm_q)
  );

  modrm_decode u_modrm_decode (
    .modrm(modrm), .mod(mod), .regm(regm), .rm(rm), .base(base), .index(index),
    .need_off_mod(need_off_mod), .off_size_mod(off_size_mod)
  );

  opcode_lookup u_opcode_lookup (
    .opcode(opcode), .modrm(modrm), .mod(mod), .regm(regm), .rm(rm),
    .base(base), .index(index), .need_off_mod(need_off_mod), .off_size_mod(off_size_mod),
    .off_word(off_q), .imm_word(imm_q),
    .need_modrm(need_modrm), .need_off(need_off), .off_size(off_size),
    .need_imm(need_imm), .imm_size(imm_size), .ninstrs(ninstrs),
    .irs(irs), .offs(offs), .imms(imms)
  );

  micro_seq_counter u_micro_seq_counter (
    .clk(clk), .reset(reset), .clear(seq_clear), .step(seq_step),
    .count(ninstrs), .idx(idx), .last(last)
  );

  fetch_fsm u_fetch_fsm (
    .clk(clk), .reset(reset), .data(data),
    .need_modrm(need_modrm), .need_off(need_off), .off_size(off_size),
    .need_imm(need_imm), .imm_size(imm_size), .ninstrs(ninstrs),
    .irs(irs), .offs(offs), .imms(imms), .idx(idx), .last(last),
    .load_opcode(load_opcode), .load_modrm(load_modrm),
    .load_off(load_off), .load_imm(load_imm),
    .seq_clear(seq_clear), .seq_step(seq_step),
    .ir(ir), .off(off), .imm(imm), .bytefetch(bytefetch), .fetch_or_exec(fetch_or_exec)
  );

endmodule

/* hdl/micro_seq_counter.sv */
`timescale 1ns/1ns

module micro_seq_counter (
  input  logic                clk,
  input  logic                reset,
  input  logic                clear,
  input  logic                step,
  input  fetch_pkg::uop_idx_t count,
  output fetch_pkg::uop_idx_t idx,
  output logic                last
);
  import fetch_pkg::*;

  uop_idx_t idx_next;

  assign idx_next = idx + 2'd1;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      idx <= '0;
    end else if (step) begin
      idx <= idx_next; // one slot per exec cycle
    end
  end

  assign last = (idx_next == count);

endmodule

/* hdl/modrm_decode.sv */
`timescale 1ns/1ns

module modrm_decode (
  input  logic [7:0] modrm,
  output logic [1:0] mod,
  output logic [2:0] regm,
  output logic [2:0] rm,
  output logic [3:0] base,
  output logic [3:0] index,
  output logic       need_off_mod,
  output logic       off_size_mod
);
  import fetch_pkg::*;

  logic direct; // [disp16] with no base or index

  assign mod  = modrm[7:6];
  assign regm = modrm[5:3];
  assign rm   = modrm[2:0];

  // 16-bit effective address registers
  always_comb begin
    case (rm)
      3'b000: begin base = reg_bx;   index = reg_si;   end
      3'b001: begin base = reg_bx;   index = reg_di;   end
      3'b010: begin base = reg_bp;   index = reg_si;   end
      3'b011: begin base = reg_bp;   index = reg_di;   end
      3'b100: begin base = reg_none; index = reg_si;   end
      3'b101: begin base = reg_none; index = reg_di;   end
      3'b110: begin
        base  = (mod != 2'b00) ? reg_bp : reg_none; // mod 00 means direct
        index = reg_none;
      end
      default: begin base = reg_bx; index = reg_none; end
    endcase
  end

  assign direct = (rm == 3'b110) && (mod == 2'b00);

  // disp8 for mod 01, disp16 for mod 10 or direct
  assign need_off_mod = direct || (mod == 2'b01) || (mod == 2'b10);
  assign off_size_mod = direct || (mod == 2'b10);

endmodule

/* hdl/opcode_lookup.sv */
`timescale 1ns/1ns

module opcode_lookup (
  input  logic [7:0]          opcode,
  input  logic [7:0]          modrm,
  input  logic [1:0]          mod,
  input  logic [2:0]          regm,
  input  logic [2:0]          rm,
  input  logic [3:0]          base,
  input  logic [3:0]          index,
  input  logic                need_off_mod,
  input  logic                off_size_mod,
  input  logic [15:0]         off_word,
  input  logic [15:0]         imm_word,
  output logic                need_modrm,
  output logic                need_off,
  output logic                off_size,
  output logic                need_imm,
  output logic                imm_size,
  output fetch_pkg::uop_idx_t ninstrs,
  output fetch_pkg::ir_t      irs  [fetch_pkg::max_uops],
  output logic [15:0]         offs [fetch_pkg::max_uops],
  output logic [15:0]         imms [fetch_pkg::max_uops]
);
  import fetch_pkg::*;

  logic        b;        // byte operation
  logic        d;        // direction, reg field is the destination
  logic        reg_mode; // mod 11, no memory operand
  logic        sm, dm;   // source or destination in memory
  logic [2:0]  dst, src;
  logic [2:0]  ff_op;    // group ff sub-opcode
  logic [15:0] off_mem;
  logic [15:0] imm_sx;

  function automatic logic [15:0] sext8(input logic [7:0] v);
    return {{8{v[7]}}, v};
  endfunction

  assign b        = ~opcode[0];
  assign d        = opcode[1];
  assign reg_mode = (mod == 2'b11);
  assign dst      = d ? regm : rm;
  assign src      = d ? rm : regm;
  assign sm       = d & ~reg_mode;
  assign dm       = ~d & ~reg_mode;
  assign ff_op    = modrm[5:3];

  // displacement after modrm, disp8 sign extended
  assign off_mem = off_size_mod ? off_word : sext8(off_word[7:0]);
  assign imm_sx  = sext8(imm_word[7:0]);

  always_comb begin
    need_modrm = 1'b0;
    need_off   = 1'b0;
    off_size   = 1'b0;
    need_imm   = 1'b0;
    imm_size   = 1'b0;
    ninstrs    = 2'd0; // unknown opcodes issue nothing
    for (int i = 0; i < max_uops; i++) begin
      irs[i]  = '0;
      offs[i] = '0;
      imms[i] = '0;
    end

    casez (opcode)
      8'b1000_10??, 8'b1000_1100, 8'b1000_1110: begin // mov r/m, incl. segment regs
        need_modrm = 1'b1;
        off_size   = off_size_mod;
        offs[0]    = off_mem;
        ninstrs    = 2'd1;
        if (dm) begin // store
          //         ac ab    im    ma    by               fun     t       wh    wr     wm    wf
          irs[0] = {b, 1'b0, 1'b0, 1'b0, b & ~opcode[2], 3'b000, 3'b111, 1'b0, 2'b00, 1'b1, 1'b0,
                    4'b0000, {opcode[2] & ~opcode[1], src}, index, base, seg_ds};
          need_off = need_off_mod;
        end else if (sm) begin // load
          irs[0] = {b, 1'b0, 1'b0, 1'b0, b & ~opcode[2], 3'b000, 3'b111, 1'b0, 2'b01, 1'b0, 1'b0,
                    {opcode[2] & opcode[1], dst}, 4'b0000, index, base, seg_ds};
          need_off = need_off_mod;
        end else begin // reg to reg through the alu
          irs[0] = {1'b0, b & ~opcode[2], 1'b1, 1'b1, b, 3'b001, 3'b001, 1'b0, 2'b01, 1'b0, 1'b0,
                    {opcode[2] & opcode[1], dst}, 4'b0000, 4'b0000,
                    {opcode[2] & ~opcode[1], src}, 2'b00};
        end
      end

      8'b1010_00??: begin // mov acc <-> [disp16]
        if (opcode[1]) begin
          irs[0] = {b, 1'b0, 1'b0, 1'b0, b, 3'b000, 3'b111, 1'b0, 2'b00, 1'b1, 1'b0,
                    4'b0000, 4'b0000, reg_none, reg_none, seg_ds};
        end else begin
          irs[0] = {b, 1'b0, 1'b0, 1'b0, b, 3'b000, 3'b111, 1'b0, 2'b01, 1'b0, 1'b0,
                    4'b0000, 4'b0000, reg_none, reg_none, seg_ds};
        end
        need_off = 1'b1;
        off_size = 1'b1;
        offs[0]  = off_word;
        ninstrs  = 2'd1;
      end

      8'b1011_????: begin // mov reg, imm
        irs[0] = {1'b0, 1'b0, 1'b1, 1'b1, ~opcode[3], 3'b001, 3'b001, 1'b0, 2'b01, 1'b0, 1'b0,
                  {1'b0, opcode[2:0]}, 4'b0000, 4'b0000, reg_none, 2'b00};
        imms[0]  = opcode[3] ? imm_word : imm_sx;
        need_imm = 1'b1;
        imm_size = opcode[3];
        ninstrs  = 2'd1;
      end

      8'b1100_011?: begin // mov r/m, imm via tmp
        irs[0] = {1'b0, 1'b0, 1'b1, 1'b1, b, 3'b001, 3'b001, 1'b0, 2'b01, 1'b0, 1'b0,
                  reg_tmp, 4'b0000, 4'b0000, reg_none, 2'b00};
        irs[1] = {1'b0, 1'b0, 1'b0, 1'b0, b, 3'b000, 3'b111, 1'b0, 2'b00, 1'b1, 1'b0,
                  4'b0000, reg_tmp, index, base, seg_ds};
        imms[0]    = b ? imm_sx : imm_word;
        offs[1]    = off_mem;
        need_modrm = 1'b1;
        need_off   = need_off_mod;
        off_size   = off_size_mod;
        need_imm   = 1'b1;
        imm_size   = ~b;
        ninstrs    = 2'd2;
      end

      8'b1110_10?1: begin // jmp near (e9) and short (eb)
        irs[0] = {1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 3'b001, 3'b001, 1'b0, 2'b01, 1'b0, 1'b0,
                  reg_ip, 4'b0000, 4'b0000, reg_ip, 2'b00};
        imms[0]  = opcode[1] ? imm_sx : imm_word;
        need_imm = 1'b1;
        imm_size = ~opcode[1];
        ninstrs  = 2'd1;
      end

      8'b1110_1010: begin // jmp far, off is new ip, imm is new cs
        irs[0] = {1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 3'b001, 3'b001, 1'b0, 2'b01, 1'b0, 1'b0,
                  reg_cs, 4'b0000, 4'b0000, reg_none, 2'b00};
        irs[1] = {1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 3'b001, 3'b001, 1'b0, 2'b01, 1'b0, 1'b0,
                  reg_ip, 4'b0000, 4'b0000, reg_none, 2'b00};
        imms[0]  = imm_word;
        imms[1]  = off_word;
        need_off = 1'b1;
        off_size = 1'b1;
        need_imm = 1'b1;
        imm_size = 1'b1;
        ninstrs  = 2'd2;
      end

      8'b1111_1111: begin // group ff
        need_modrm = 1'b1;
        need_off   = need_off_mod;
        off_size   = off_size_mod;
        offs[0]    = off_mem;
        if (ff_op == 3'b100) begin // jmp near indirect
          if (reg_mode) begin
            irs[0] = {1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 3'b001, 3'b001, 1'b0, 2'b01, 1'b0, 1'b0,
                      reg_ip, 4'b0000, 4'b0000, {1'b0, src}, 2'b00};
          end else begin
            irs[0] = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000, 3'b111, 1'b0, 2'b01, 1'b0, 1'b0,
                      reg_ip, 4'b0000, index, base, seg_ds};
          end
          ninstrs = 2'd1;
        end else if (ff_op == 3'b101) begin // jmp far indirect, ip then cs
          irs[0] = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000, 3'b111, 1'b0, 2'b01, 1'b0, 1'b0,
                    reg_ip, 4'b0000, index, base, seg_ds};
          irs[1] = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3'b001, 3'b111, 1'b0, 2'b01, 1'b0, 1'b0,
                    reg_cs, 4'b0000, index, base, seg_ds};
          offs[1] = off_mem;
          ninstrs = 2'd2;
        end
      end

      default: ;
    endcase
  end

endmodule

/* hdl/operand_latch.sv */
`timescale 1ns/1ns

module operand_latch #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     load,
  input  payload_t d,
  output payload_t q
);

  // holds a fetched byte or word until the next instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else if (load) begin
      q <= d;
    end
  end

endmodule

/* sim.f */
hdl/fetch_pkg.sv
hdl/operand_latch.sv
hdl/modrm_decode.sv
hdl/opcode_lookup.sv
hdl/micro_seq_counter.sv
hdl/fetch_fsm.sv
hdl/fetch_unit.sv
test/tb_fetch_unit.sv

/* test/fetch_tests.txt */
# name, byte count, code bytes, micro-op count, then ir off imm per micro-op
# an off or imm of - is left over from earlier latches and is not compared
mov_rr        2 89 d8             1 0c490000c - 0000
mov_ri        3 b8 34 12          1 0c4900030 0000 1234
jmp_short     2 eb f0             1 0c493c03c 0000 fff0
jmp_near      3 e9 00 10          1 0c493c03c 0000 1000
mov_ld_d8     3 8b 47 10          1 00390030f 0010 0000
mov_ld_bpsi   3 8a 42 fe          1 223900197 fffe 0000
mov_st_d16    4 89 87 34 12       1 00388030f 1234 0000
mov_ld_dir    4 8b 1e 78 56       1 00390c333 5678 0000
mov_mi        6 c7 06 34 12 cd ab 2 0c4934030 0000 abcd 003883733 1234 0000
jmp_far       5 ea 00 01 00 f0    2 0c4924030 0000 f000 0c493c030 0000 0100
jmp_ind_reg   2 ff e3             1 0c493c00c - 0000
jmp_ind_mem   2 ff 27             1 00393c30f - 0000
jmpf_ind_mem  3 ff 6e 04          2 00393c317 0004 0000 007924317 0004 0000
jmpf_ind_reg  2 ff eb             2 00393c1d7 - 0000 0079241d7 - 0000

/* test/tb_fetch_unit.sv */
`timescale 1ns/1ns

module tb_fetch_unit;
  import fetch_pkg::*;

  localparam int mem_bytes = 258; // code stream plus filler

  logic        clk;
  logic        reset;
  logic [15:0] cs, ip, data;
  logic [19:0] pc;
  ir_t         ir;
  logic [15:0] off, imm;
  logic        bytefetch, fetch_or_exec;

  logic [7:0]  mem [mem_bytes];
  logic [7:0]  code_q [$];
  ir_t         exp_ir [$];
  logic [15:0] exp_off [$];
  logic [15:0] exp_imm [$];
  bit          off_care [$];
  bit          imm_care [$];
  string       names [$];
  int          code_start [$], code_len [$], uop_start [$], uop_cnt [$];
  int          errors;
  int          failed_tests;
  bit          loaded;

  fetch_unit u_fetch_unit (
    .clk(clk), .reset(reset), .cs(cs), .ip(ip), .data(data), .pc(pc), .ir(ir),
    .off(off), .imm(imm), .bytefetch(bytefetch), .fetch_or_exec(fetch_or_exec)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [33:0] expv, input logic [33:0] gotv);
    if (gotv !== expv) begin
      $display("ERR %0t %s expected %h got %h", $time, name, expv, gotv);
      errors++;
    end
  endtask

  // off and imm columns may hold - when the value is left over from earlier latches
  task automatic read_field(input int fd, output logic [15:0] v, output bit care);
    string tok;
    v = '0;
    care = 1'b0;
    void'($fscanf(fd, "%s", tok));
    if (tok != "-") begin
      care = 1'b1;
      void'($sscanf(tok, "%h", v));
    end
  endtask

  task automatic load_tests();
    int          fd, n, k;
    string       tok, rest;
    logic [7:0]  b;
    ir_t         v_ir;
    logic [15:0] v;
    bit          care;
    fd = $fopen("test/fetch_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open test/fetch_tests.txt");
      errors++;
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.substr(0, 0) == "#") begin
        void'($fgets(rest, fd)); // comment line
      end else begin
        names.push_back(tok);
        code_start.push_back(code_q.size());
        void'($fscanf(fd, "%d", n));
        code_len.push_back(n);
        for (k = 0; k < n; k++) begin
          void'($fscanf(fd, "%h", b));
          code_q.push_back(b);
        end
        uop_start.push_back(exp_ir.size());
        void'($fscanf(fd, "%d", n));
        uop_cnt.push_back(n);
        for (k = 0; k < n; k++) begin
          void'($fscanf(fd, "%h", v_ir));
          exp_ir.push_back(v_ir);
          read_field(fd, v, care);
          exp_off.push_back(v);
          off_care.push_back(care);
          read_field(fd, v, care);
          exp_imm.push_back(v);
          imm_care.push_back(care);
        end
      end
    end
    $fclose(fd);
  endtask

  // code at address 0, random bytes behind it
  task automatic fill_memory(input int start, input int len);
    for (int i = 0; i < mem_bytes; i++) begin
      mem[i] = 8'($urandom);
    end
    for (int i = 0; i < len; i++) begin
      mem[i] = code_q[start + i];
    end
  endtask

  task automatic drive_data(input int ptr);
    data = {mem[ptr + 1], mem[ptr]}; // low byte first
  endtask

  task automatic reset_dut();
    @(posedge clk);
    #5;
    reset = 1'b1;
    cs = 16'($urandom);
    ip = 16'($urandom);
    drive_data(0);
    repeat (2) @(posedge clk);
    #5;
    check_value("ir", '0, ir);
    check_value("fetch_or_exec", 34'd0, 34'(fetch_or_exec));
    check_value("pc", 34'(20'(cs) * 20'd16 + 20'(ip)), 34'(pc));
    reset = 1'b0;
  endtask

  task automatic run_code(input int len, input int first, input int count);
    int  ptr, got, adv;
    ir_t prev;
    bit  done;
    ptr = 0;
    got = 0;
    prev = '0;
    done = 1'b0;
    drive_data(ptr);
    while (!done) begin
      @(negedge clk);
      adv = 0;
      if (ir == add_ip) begin
        check_value("fetch_or_exec", 34'd0, 34'(fetch_or_exec));
        if (prev != '0 && prev != add_ip) begin
          $display("micro-op at %0t was not followed by a cleared ir", $time);
          errors++;
        end
        if (imm != 16'd1 && imm != 16'd2) begin
          check_value("imm", 34'd1, 34'(imm));
        end else begin
          check_value("bytefetch", 34'(imm == 16'd1), 34'(bytefetch));
          adv = int'(imm);
        end
      end else if (ir != '0) begin
        check_value("fetch_or_exec", 34'd1, 34'(fetch_or_exec));
        if (got >= count) begin
          $display("unexpected extra micro-op %h at %0t", ir, $time);
          errors++;
        end else begin
          check_value("ir", exp_ir[first + got], ir);
          if (off_care[first + got]) check_value("off", 34'(exp_off[first + got]), 34'(off));
          if (imm_care[first + got]) check_value("imm", 34'(exp_imm[first + got]), 34'(imm));
          got++;
        end
      end else if (!fetch_or_exec && ptr >= len) begin
        done = 1'b1; // idle after the last instruction
      end
      prev = ir;
      if (!done) begin
        @(posedge clk);
        #5;
        ptr += adv;
        drive_data(ptr);
      end
    end
    if (got != count) begin
      $display("only %0d of %0d micro-ops were issued", got, count);
      errors++;
    end
    if (ptr != len) begin
      $display("fetch consumed %0d bytes where the code has %0d", ptr, len);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s with %0d errors", name, errs);
      failed_tests++;
    end
  endtask

  initial begin
    int e0;
    void'($urandom(32'h6e8dfe31));
    reset = 1'b1;
    cs = '0;
    ip = '0;
    data = '0;
    errors = 0;
    failed_tests = 0;
    loaded = 1'b0;
    load_tests();
    loaded = 1'b1;
    if (names.size() == 0) begin
      $display("no tests were loaded");
      errors++;
    end
    for (int t = 0; t < names.size(); t++) begin
      e0 = errors;
      fill_memory(code_start[t], code_len[t]);
      reset_dut();
      run_code(code_len[t], uop_start[t], uop_cnt[t]);
      report_test(names[t], errors - e0);
    end
    // whole stream back to back, no reset in between
    e0 = errors;
    fill_memory(0, code_q.size());
    reset_dut();
    run_code(code_q.size(), 0, exp_ir.size());
    report_test("stream", errors - e0);
    $display("tests %0d, failed %0d, errors %0d", names.size() + 1, failed_tests, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (loaded);
    // both passes, with reset, clear and idle cycles per test
    limit = 2 * (code_q.size() + exp_ir.size() + 3 * names.size()) + 3 * names.size() + 50;
    #(limit * 100);
    $display("timeout, the tests did not finish within %0d clock cycles", limit);
    $display("Regression failed");
    $finish;
  end

endmodule
